// ==== Makefile ====
TOP := sort_tb
BUILD := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP)

clean:
	rm -rf $(BUILD)

// ==== design/sort_layer.sv ====
module sort_layer
	import sort_pkg::*;
#(
	parameter int LANES = DEF_LANES,
	parameter int KEY_WIDTH = DEF_KEY_WIDTH,
	parameter int LAYER = 0
)
(
	input logic clk,
	input logic reset,
	input logic [LANES*KEY_WIDTH-1:0] keys_in,
	input tag_t [LANES-1:0] tags_in,
	output logic [LANES*KEY_WIDTH-1:0] keys_out,
	output tag_t [LANES-1:0] tags_out
);

	// pipeline register of this layer
	// keys and tags move together
	logic [LANES*KEY_WIDTH-1:0] keys_q;
	tag_t [LANES-1:0] tags_q;

	// per lane exchange select
	// both members of a pair carry the same bit
	logic [LANES-1:0] swap;

	// one stage of the pipe, new vector every edge
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			keys_q <= '0;
			tags_q <= '0;
		end
		else
		begin
			keys_q <= keys_in;
			tags_q <= tags_in;
		end
	end

	// compare-exchange on the registered vector
	// pairing is fixed per LAYER, so every lane resolves
	// its partner and role while elaborating
	generate
		for (genvar j = 0; j < LANES; j++)
		begin : lane_g
			localparam int PARTNER = layer_partner(LANES, LAYER, j);
			localparam bit UPPER = lane_is_upper(LANES, LAYER, j);

			logic [KEY_WIDTH-1:0] own_key;
			logic [KEY_WIDTH-1:0] other_key;

			// own key and the key across the pair
			// for an unpaired lane both are the same slice
			assign own_key = keys_q[j*KEY_WIDTH +: KEY_WIDTH];
			assign other_key = keys_q[PARTNER*KEY_WIDTH +: KEY_WIDTH];

			if (PARTNER == j)
			begin : idle_g
				// not touched by this layer
				assign swap[j] = 1'b0;
			end
			else if (UPPER)
			begin : cmp_g
				// the single comparator of the pair
				// larger key wants the lower lane, equal keys stay put
				assign swap[j] = own_key < other_key;
			end
			else
			begin : follow_g
				// higher lane follows the comparator of its partner
				assign swap[j] = swap[PARTNER];
			end

			// output mux, key and tag switch together
			assign keys_out[j*KEY_WIDTH +: KEY_WIDTH] = swap[j] ? other_key : own_key;
			assign tags_out[j] = swap[j] ? tags_q[PARTNER] : tags_q[j];
		end
	endgenerate

endmodule

// ==== design/sort_pkg.sv ====
package sort_pkg;

	// default network size, the top level overrides both
	localparam int DEF_LANES = 16;
	localparam int DEF_KEY_WIDTH = 8;

	// largest network the tag type can number
	localparam int MAX_LANES = 64;
	localparam int TAG_WIDTH = $clog2(MAX_LANES);

	// original lane number carried alongside each key
	typedef logic [TAG_WIDTH-1:0] tag_t;

	// layers in a Batcher odd-even merge network of n lanes
	// log2(n) merge spans, span number s contributes s+1 layers
	function automatic int num_layers(input int n);
		int lg;
		lg = $clog2(n);
		return lg * (lg + 1) / 2;
	endfunction

	// partner of a lane in one layer, or the lane itself when unpaired
	// layers are counted over span p = 1, 2, 4 .. below n
	// and inside each span over distance k = p, p/2 .. 1
	function automatic int layer_partner(input int n, input int layer, input int lane);
		int idx;
		int p;
		int k;
		int base;
		int off;
		int result;
		idx = 0;
		result = lane;
		for (p = 1; p < n; p = p * 2)
		begin
			for (k = p; k >= 1; k = k / 2)
			begin
				if (idx == layer)
				begin
					// first compared lane of this layer
					base = k % p;
					off = lane - base;
					if (off >= 0 && (off % (2 * k)) < k)
					begin
						// lower member, partner sits k lanes up
						// only inside the same block of 2p lanes
						if (lane + k < n && (lane / (2 * p)) == ((lane + k) / (2 * p)))
						begin
							result = lane + k;
						end
					end
					else if (off >= k)
					begin
						// upper member, partner sits k lanes down
						if ((lane / (2 * p)) == ((lane - k) / (2 * p)))
						begin
							result = lane - k;
						end
					end
				end
				idx++;
			end
		end
		return result;
	endfunction

	// lane holds the larger key of its pair after the exchange
	// true for the lower-numbered member only
	function automatic bit lane_is_upper(input int n, input int layer, input int lane);
		int partner;
		partner = layer_partner(n, layer, lane);
		return partner > lane;
	endfunction

endpackage

// ==== design/sort_top.sv ====
module sort_top
	import sort_pkg::*;
#(
	parameter int LANES = DEF_LANES,
	parameter int KEY_WIDTH = DEF_KEY_WIDTH
)
(
	input logic clk,
	input logic reset,
	input logic [LANES*KEY_WIDTH-1:0] candidate,
	output logic [LANES*$clog2(LANES)-1:0] index_sorted
);

	// network depth, 10 layers for 16 lanes
	localparam int LAYERS = num_layers(LANES);
	// bits of a lane number on the output
	localparam int INDEX_WIDTH = $clog2(LANES);

	// lane count must suit the merge network and the tag type
	generate
		if (LANES < 2 || LANES > MAX_LANES || (LANES & (LANES - 1)) != 0)
		begin : lanes_check_g
			$error("sort_top: LANES must be a power of two from 2 to %0d", MAX_LANES);
		end
	endgenerate

	// links between layers
	// entry 0 is the network input, entry L+1 the output of layer L
	// last key entry has no reader, keys only steer the exchanges
	logic [LANES*KEY_WIDTH-1:0] keys_chain [LAYERS+1];
	tag_t [LANES-1:0] tags_chain [LAYERS+1];

	// final tags cut down to lane-number width
	logic [LANES*INDEX_WIDTH-1:0] final_index;

	// keys enter straight into layer 0
	assign keys_chain[0] = candidate;

	// seed tags, lane j starts out tagged j
	generate
		for (genvar j = 0; j < LANES; j++)
		begin : seed_g
			assign tags_chain[0][j] = tag_t'(j);
		end
	endgenerate

	// one registered layer per network layer
	generate
		for (genvar l = 0; l < LAYERS; l++)
		begin : layer_g
			sort_layer #(
				.LANES(LANES),
				.KEY_WIDTH(KEY_WIDTH),
				.LAYER(l)
			) u_layer (
				.clk(clk),
				.reset(reset),
				.keys_in(keys_chain[l]),
				.tags_in(tags_chain[l]),
				.keys_out(keys_chain[l+1]),
				.tags_out(tags_chain[l+1])
			);
		end
	endgenerate

	// rank r slice holds the lane of the r-th largest key
	// upper tag bits are always zero here
	generate
		for (genvar r = 0; r < LANES; r++)
		begin : index_g
			assign final_index[r*INDEX_WIDTH +: INDEX_WIDTH] =
				tags_chain[LAYERS][r][INDEX_WIDTH-1:0];
		end
	endgenerate

	// output register
	// LAYERS+1 register stages from candidate to index_sorted
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			index_sorted <= '0;
		end
		else
		begin
			index_sorted <= final_index;
		end
	end

endmodule

// ==== filelist.f ====
design/sort_pkg.sv
design/sort_layer.sv
design/sort_top.sv
sim/sort_layer_checker.sv
sim/sort_tb.sv

// ==== sim/sort_layer_checker.sv ====
module sort_layer_checker
	import sort_pkg::*;
#(
	parameter int LANES = DEF_LANES,
	parameter int KEY_WIDTH = DEF_KEY_WIDTH,
	parameter int LAYER = 0
)
(
	input logic clk,
	input logic reset,
	input logic [LANES*KEY_WIDTH-1:0] keys_out,
	input tag_t [LANES-1:0] tags_out
);

	// one bit per lane that exists in this network
	localparam logic [MAX_LANES-1:0] ALL_LANES = {MAX_LANES{1'b1}} >> (MAX_LANES - LANES);

	// reset as seen on the previous edge
	logic reset_d;
	// edges since reset, stops once this layer holds seeded tags
	int fill;
	// lanes named by the current tag vector
	logic [MAX_LANES-1:0] seen;

	always_ff @(posedge clk)
	begin
		reset_d <= reset;
	end

	// layer L holds real tags after L+1 edges out of reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fill <= 0;
		end
		else if (fill <= LAYER)
		begin
			fill <= fill + 1;
		end
	end

	always_comb
	begin
		seen = '0;
		for (int j = 0; j < LANES; j++)
		begin
			seen[tags_out[j]] = 1'b1;
		end
	end

	// registers cleared, so exchange outputs are all zero
	cleared_a: assert property (@(posedge clk) reset_d |-> (keys_out == '0 && tags_out == '0))
		else $error("layer %0d outputs not zero after reset", LAYER);

	// every lane number exactly once
	permutation_a: assert property (@(posedge clk) disable iff (reset)
		(fill > LAYER) |-> (seen == ALL_LANES))
		else $error("layer %0d tags are not a permutation of the lanes", LAYER);

	// larger key sits in the lower lane of each pair
	generate
		for (genvar j = 0; j < LANES; j++)
		begin : lane_g
			localparam int PARTNER = layer_partner(LANES, LAYER, j);
			if (PARTNER > j)
			begin : pair_g
				ordered_a: assert property (@(posedge clk) disable iff (reset)
					keys_out[j*KEY_WIDTH +: KEY_WIDTH] >= keys_out[PARTNER*KEY_WIDTH +: KEY_WIDTH])
					else $error("layer %0d lanes %0d and %0d out of order", LAYER, j, PARTNER);
			end
		end
	endgenerate

endmodule

bind sort_layer sort_layer_checker #(
	.LANES(LANES),
	.KEY_WIDTH(KEY_WIDTH),
	.LAYER(LAYER)
) layer_check (
	.clk(clk),
	.reset(reset),
	.keys_out(keys_out),
	.tags_out(tags_out)
);

// ==== sim/sort_tb.sv ====
module sort_tb;

	localparam int LANES = 16;
	localparam int KEY_WIDTH = 8;
	localparam int INDEX_WIDTH = 4;
	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	// eleven register stages, the sampling edge loads the first
	localparam int LATENCY = 11;
	localparam int DRAIN_TIMEOUT = 40;

	logic clk;
	logic reset;
	logic [LANES*KEY_WIDTH-1:0] candidate;
	logic [LANES*INDEX_WIDTH-1:0] index_sorted;

	// xorshift state
	logic [31:0] rng_state = 32'h320b_bcb1;

	// edge bookkeeping, updated on every rising edge
	int edge_count = 0;
	// last edge that sampled reset high
	int reset_edge = 0;

	// vectors in flight, one entry per applied vector
	logic [LANES*KEY_WIDTH-1:0] pending_keys[$];
	logic [LANES*INDEX_WIDTH-1:0] pending_order[$];
	bit pending_exact[$];
	int pending_due[$];

	int pushed_count = 0;
	int checked_count = 0;

	sort_top #(
		.LANES(LANES),
		.KEY_WIDTH(KEY_WIDTH)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.candidate(candidate),
		.index_sorted(index_sorted)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
	begin
		edge_count <= edge_count + 1;
		if (reset)
		begin
			reset_edge <= edge_count + 1;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_random(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state;
	endtask

	function automatic logic [KEY_WIDTH-1:0] key_of(input logic [LANES*KEY_WIDTH-1:0] keys,
		input int lane);
		return keys[lane*KEY_WIDTH +: KEY_WIDTH];
	endfunction

	// expected ranking, largest key first
	// selection over the lanes not yet ranked, ties to the lower lane
	function automatic logic [LANES*INDEX_WIDTH-1:0] reference_order(
		input logic [LANES*KEY_WIDTH-1:0] keys);
		logic [LANES-1:0] taken;
		logic [LANES*INDEX_WIDTH-1:0] order;
		int best;
		taken = '0;
		order = '0;
		for (int r = 0; r < LANES; r++)
		begin
			best = -1;
			for (int j = 0; j < LANES; j++)
			begin
				if (!taken[j] && (best < 0 || key_of(keys, j) > key_of(keys, best)))
				begin
					best = j;
				end
			end
			taken[best] = 1'b1;
			order[r*INDEX_WIDTH +: INDEX_WIDTH] = INDEX_WIDTH'(best);
		end
		return order;
	endfunction

	task automatic stop_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected)
		begin
			$display("Error: %s is %h, expected %h", name, got, expected);
			stop_with_failure();
		end
	endtask

	// ties have no single right answer
	// output must name every lane once, keys never rising
	task automatic check_ranked(input logic [LANES*KEY_WIDTH-1:0] keys,
		input logic [LANES*INDEX_WIDTH-1:0] got);
		logic [LANES-1:0] seen;
		int hi;
		int lo;
		seen = '0;
		for (int r = 0; r < LANES; r++)
		begin
			seen[got[r*INDEX_WIDTH +: INDEX_WIDTH]] = 1'b1;
		end
		check_value("index_sorted lane set", 64'(seen), 64'({LANES{1'b1}}));
		for (int r = 0; r < LANES - 1; r++)
		begin
			hi = int'(got[r*INDEX_WIDTH +: INDEX_WIDTH]);
			lo = int'(got[(r+1)*INDEX_WIDTH +: INDEX_WIDTH]);
			check_value($sformatf("index_sorted key order at rank %0d", r),
				64'(key_of(keys, hi) >= key_of(keys, lo)), 64'd1);
		end
	endtask

	// drive one vector after the edge, result due LATENCY edges on
	task automatic apply_vector(input logic [LANES*KEY_WIDTH-1:0] keys,
		input logic [LANES*INDEX_WIDTH-1:0] expected, input bit exact);
		@(posedge clk);
		#DRIVE_DELAY;
		candidate = keys;
		pending_keys.push_back(keys);
		pending_order.push_back(expected);
		pending_exact.push_back(exact);
		pending_due.push_back(edge_count + LATENCY);
		pushed_count++;
	endtask

	task automatic apply_distinct();
		logic [(1<<KEY_WIDTH)-1:0] used;
		logic [LANES*KEY_WIDTH-1:0] keys;
		logic [31:0] r;
		logic [KEY_WIDTH-1:0] k;
		int j;
		used = '0;
		keys = '0;
		j = 0;
		// redraw until every lane has its own key
		while (j < LANES)
		begin
			next_random(r);
			k = r[KEY_WIDTH-1:0];
			if (!used[k])
			begin
				used[k] = 1'b1;
				keys[j*KEY_WIDTH +: KEY_WIDTH] = k;
				j++;
			end
		end
		apply_vector(keys, reference_order(keys), 1'b1);
	endtask

	// keys drawn from only four values
	task automatic apply_tied();
		logic [KEY_WIDTH-1:0] values [4];
		logic [LANES*KEY_WIDTH-1:0] keys;
		logic [31:0] r;
		for (int i = 0; i < 4; i++)
		begin
			next_random(r);
			values[i] = r[KEY_WIDTH-1:0];
		end
		for (int j = 0; j < LANES; j++)
		begin
			next_random(r);
			keys[j*KEY_WIDTH +: KEY_WIDTH] = values[r[9:8]];
		end
		apply_vector(keys, '0, 1'b0);
	endtask

	// strictly monotonic keys with a known ranking
	// offset stays below 60 so keys fit in 8 bits
	task automatic apply_monotonic(input bit rising, input int offset);
		logic [LANES*KEY_WIDTH-1:0] keys;
		logic [LANES*INDEX_WIDTH-1:0] order;
		for (int j = 0; j < LANES; j++)
		begin
			if (rising)
			begin
				keys[j*KEY_WIDTH +: KEY_WIDTH] = KEY_WIDTH'(offset + 13 * j);
				order[(LANES-1-j)*INDEX_WIDTH +: INDEX_WIDTH] = INDEX_WIDTH'(j);
			end
			else
			begin
				keys[j*KEY_WIDTH +: KEY_WIDTH] = KEY_WIDTH'(offset + 13 * (LANES - 1 - j));
				order[j*INDEX_WIDTH +: INDEX_WIDTH] = INDEX_WIDTH'(j);
			end
		end
		apply_vector(keys, order, 1'b1);
	endtask

	task automatic pulse_reset(input int cycles);
		@(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b1;
		repeat (cycles) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
	endtask

	task automatic wait_for_results();
		int waited;
		waited = 0;
		while (pending_due.size() > 0)
		begin
			if (waited >= DRAIN_TIMEOUT)
			begin
				$display("Timeout: %0d queued vectors never reached index_sorted",
					pending_due.size());
				stop_with_failure();
			end
			@(posedge clk);
			waited++;
		end
	endtask

	// compare at the falling edge, outputs settled since the rising one
	initial
	begin : compare_proc
		logic [LANES*KEY_WIDTH-1:0] keys;
		logic [LANES*INDEX_WIDTH-1:0] order;
		bit exact;
		forever
		begin
			@(negedge clk);
			// vectors caught in the pipe by a reset never come out
			while (pending_due.size() > 0 && pending_due[0] <= reset_edge + LATENCY - 1)
			begin
				void'(pending_keys.pop_front());
				void'(pending_order.pop_front());
				void'(pending_exact.pop_front());
				void'(pending_due.pop_front());
			end
			if (edge_count <= reset_edge + LATENCY - 1)
			begin
				// in reset or pipe still refilling
				check_value("index_sorted", index_sorted, 64'd0);
			end
			else if (pending_due.size() > 0 && pending_due[0] == edge_count)
			begin
				keys = pending_keys.pop_front();
				order = pending_order.pop_front();
				exact = pending_exact.pop_front();
				void'(pending_due.pop_front());
				if (exact)
				begin
					check_value("index_sorted", index_sorted, order);
				end
				else
				begin
					check_ranked(keys, index_sorted);
				end
				checked_count++;
			end
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		candidate = '0;
		repeat (16) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		// back to back random vectors with distinct keys
		for (int i = 0; i < 200; i++)
		begin
			apply_distinct();
		end

		// ascending then descending
		apply_monotonic(1'b1, 3);
		apply_monotonic(1'b0, 3);

		// ties, last one all equal
		for (int i = 0; i < 20; i++)
		begin
			apply_tied();
		end
		apply_vector({LANES{8'h5a}}, '0, 1'b0);

		// orderings flip every cycle
		for (int i = 0; i < 20; i++)
		begin
			apply_monotonic(i % 2 == 0, i);
		end

		// reset lands while the pipe is full
		for (int i = 0; i < 5; i++)
		begin
			apply_distinct();
		end
		pulse_reset(3);
		for (int i = 0; i < 30; i++)
		begin
			apply_distinct();
		end

		wait_for_results();
		// the reset wiped the ten vectors sampled just before it
		// every other applied vector must have been compared
		check_value("vectors compared", 64'(checked_count), 64'(pushed_count - (LATENCY - 1)));
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
